// ==== logic/rc4_pkg.sv ====
package rc4_pkg;

    // ========================================
    // rc4 data sizes
    // ========================================

    typedef logic [7:0]  byte_t;  // state contents and indices
    typedef logic [23:0] key_t;   // msb is key byte 0

    localparam int KEY_BYTES  = 3;
    localparam int SBOX_DEPTH = 256;

    // message length when the top level is not told otherwise
    localparam int MSG_LEN_DEFAULT = 32;

endpackage

// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

    // ========================================
    // control state encodings
    // ========================================

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SCHED,
        SEQ_DECRYPT,
        SEQ_ACK
    } seq_state_e;

    typedef enum logic [2:0] {
        KSA_IDLE,
        KSA_FILL,
        KSA_READ_I,
        KSA_COMPUTE_J,
        KSA_READ_J,
        KSA_WRITE_J,
        KSA_WRITE_I,
        KSA_ACK
    } ksa_state_e;

    typedef enum logic [3:0] {
        PRGA_IDLE,
        PRGA_STEP_I,
        PRGA_READ_I,
        PRGA_UPDATE_J,
        PRGA_READ_J,
        PRGA_WRITE_J,
        PRGA_WRITE_I,
        PRGA_READ_SUM,
        PRGA_READ_CT,
        PRGA_EMIT,
        PRGA_ACK
    } prga_state_e;

    // who drives the state memory port
    typedef enum logic {
        OWN_KSA,
        OWN_PRGA
    } sbox_owner_e;

endpackage

// ==== logic/sbox_if.sv ====
interface sbox_if;
    import rc4_pkg::*;

    byte_t addr;
    byte_t wdata;
    logic  we;
    byte_t rdata;  // one cycle after addr

    modport master (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport mem (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

// ==== logic/sbox_ram.sv ====
module sbox_ram (
    input logic clk,
    sbox_if.mem mem
);
    import rc4_pkg::*;

    byte_t mem_q [SBOX_DEPTH];

    // the fill pass defines the contents
    always_ff @(posedge clk) begin
        if (mem.we) begin
            mem_q[mem.addr] <= mem.wdata;
        end
        mem.rdata <= mem_q[mem.addr];  // old data on a same-address write
    end

endmodule

// ==== logic/key_schedule.sv ====
module key_schedule (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_req,
    output logic          o_ack,
    input  rc4_pkg::key_t i_key,
    sbox_if.master        sbox
);
    import rc4_pkg::*;
    import ctrl_pkg::*;

    localparam byte_t LAST_IDX = byte_t'(SBOX_DEPTH - 1);

    ksa_state_e state_q;
    byte_t      i_q;
    byte_t      j_q;
    byte_t      si_q;
    byte_t      sj_q;
    logic [1:0] k_sel_q;   // tracks i mod 3
    byte_t      key_byte;

    // i mod 3 == 0 picks the msb key[23:16]
    assign key_byte = i_key[8 * (KEY_BYTES - 1 - int'(k_sel_q)) +: 8];

    assign o_ack = (state_q == KSA_ACK);

    // ========================================
    // control fsm
    // ========================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= KSA_IDLE;
            i_q     <= '0;
            j_q     <= '0;
            k_sel_q <= '0;
        end else begin
            case (state_q)
                KSA_IDLE: begin
                    if (i_req) begin
                        i_q     <= '0;
                        state_q <= KSA_FILL;
                    end
                end
                KSA_FILL: begin
                    i_q <= i_q + 8'd1;  // wraps back to 0 after the last entry
                    if (i_q == LAST_IDX) begin
                        j_q     <= '0;
                        k_sel_q <= '0;
                        state_q <= KSA_READ_I;
                    end
                end
                KSA_READ_I:    state_q <= KSA_COMPUTE_J;
                KSA_COMPUTE_J: begin
                    j_q     <= j_q + sbox.rdata + key_byte;  // rdata is S[i]
                    state_q <= KSA_READ_J;
                end
                KSA_READ_J:    state_q <= KSA_WRITE_J;
                KSA_WRITE_J:   state_q <= KSA_WRITE_I;
                KSA_WRITE_I: begin
                    i_q     <= i_q + 8'd1;
                    k_sel_q <= (int'(k_sel_q) == KEY_BYTES - 1) ? 2'd0 : k_sel_q + 2'd1;
                    state_q <= (i_q == LAST_IDX) ? KSA_ACK : KSA_READ_I;
                end
                KSA_ACK: begin
                    if (!i_req) begin
                        state_q <= KSA_IDLE;
                    end
                end
                default: state_q <= KSA_IDLE;
            endcase
        end
    end

    // swap operands
    always_ff @(posedge clk) begin
        if (state_q == KSA_COMPUTE_J) begin
            si_q <= sbox.rdata;
        end
        if (state_q == KSA_WRITE_J) begin
            sj_q <= sbox.rdata;  // S[j] from the read_j cycle
        end
    end

    // ========================================
    // state memory port
    // ========================================

    always_comb begin
        sbox.addr  = i_q;
        sbox.wdata = '0;
        sbox.we    = 1'b0;
        case (state_q)
            KSA_FILL: begin
                sbox.wdata = i_q;  // identity permutation
                sbox.we    = 1'b1;
            end
            KSA_READ_J: sbox.addr = j_q;
            KSA_WRITE_J: begin
                sbox.addr  = j_q;
                sbox.wdata = si_q;
                sbox.we    = 1'b1;
            end
            KSA_WRITE_I: begin
                sbox.wdata = sj_q;
                sbox.we    = 1'b1;
            end
            default: ;
        endcase
    end

    // sequencer keeps the request high for the whole run
    assert property (@(posedge clk) disable iff (rst) !i_req |-> !sbox.we);

endmodule

// ==== logic/keystream_decrypt.sv ====
module keystream_decrypt #(
    parameter int  MSG_LEN = rc4_pkg::MSG_LEN_DEFAULT,
    localparam int CT_AW   = (MSG_LEN > 1) ? $clog2(MSG_LEN) : 1
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_req,
    output logic               o_ack,
    sbox_if.master             sbox,
    output logic [CT_AW-1:0]   o_ct_addr,
    input  rc4_pkg::byte_t     i_ct_data,
    output logic               o_pt_valid,
    output logic [CT_AW-1:0]   o_pt_addr,
    output rc4_pkg::byte_t     o_pt_data
);
    import rc4_pkg::*;
    import ctrl_pkg::*;

    localparam logic [CT_AW-1:0] LAST_K = CT_AW'(MSG_LEN - 1);

    prga_state_e      state_q;
    byte_t            i_q;
    byte_t            j_q;
    byte_t            si_q;
    byte_t            sj_q;
    byte_t            pt_q;
    logic [CT_AW-1:0] k_q;  // message byte index

    assign o_ack      = (state_q == PRGA_ACK);
    assign o_ct_addr  = k_q;  // held for the whole byte iteration
    assign o_pt_valid = (state_q == PRGA_EMIT);
    assign o_pt_addr  = k_q;
    assign o_pt_data  = pt_q;

    // ========================================
    // control fsm
    // ========================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= PRGA_IDLE;
            i_q     <= '0;
            j_q     <= '0;
            k_q     <= '0;
        end else begin
            case (state_q)
                PRGA_IDLE: begin
                    if (i_req) begin
                        i_q     <= '0;
                        j_q     <= '0;
                        k_q     <= '0;
                        state_q <= PRGA_STEP_I;
                    end
                end
                PRGA_STEP_I: begin
                    i_q     <= i_q + 8'd1;  // first i is 1
                    state_q <= PRGA_READ_I;
                end
                PRGA_READ_I:   state_q <= PRGA_UPDATE_J;
                PRGA_UPDATE_J: begin
                    j_q     <= j_q + sbox.rdata;
                    state_q <= PRGA_READ_J;
                end
                PRGA_READ_J:   state_q <= PRGA_WRITE_J;
                PRGA_WRITE_J:  state_q <= PRGA_WRITE_I;
                PRGA_WRITE_I:  state_q <= PRGA_READ_SUM;
                PRGA_READ_SUM: state_q <= PRGA_READ_CT;
                PRGA_READ_CT:  state_q <= PRGA_EMIT;
                PRGA_EMIT: begin
                    if (k_q == LAST_K) begin
                        state_q <= PRGA_ACK;
                    end else begin
                        k_q     <= k_q + 1'b1;
                        state_q <= PRGA_STEP_I;
                    end
                end
                PRGA_ACK: begin
                    if (!i_req) begin
                        state_q <= PRGA_IDLE;
                    end
                end
                default: state_q <= PRGA_IDLE;
            endcase
        end
    end

    // swap operands and plaintext byte
    always_ff @(posedge clk) begin
        case (state_q)
            PRGA_UPDATE_J: si_q <= sbox.rdata;               // S[i]
            PRGA_WRITE_J:  sj_q <= sbox.rdata;               // S[j]
            PRGA_READ_CT:  pt_q <= sbox.rdata ^ i_ct_data;   // f xor ct[k]
            default: ;
        endcase
    end

    // ========================================
    // state memory port
    // ========================================

    always_comb begin
        sbox.addr  = i_q;
        sbox.wdata = '0;
        sbox.we    = 1'b0;
        case (state_q)
            PRGA_READ_J: sbox.addr = j_q;
            PRGA_WRITE_J: begin
                sbox.addr  = j_q;
                sbox.wdata = si_q;
                sbox.we    = 1'b1;
            end
            PRGA_WRITE_I: begin
                sbox.wdata = sj_q;
                sbox.we    = 1'b1;
            end
            PRGA_READ_SUM: sbox.addr = si_q + sj_q;  // wraps mod 256
            default: ;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst) o_pt_valid |=> !o_pt_valid);

endmodule

// ==== logic/rc4_sequencer.sv ====
module rc4_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_req,
    input  rc4_pkg::key_t         i_key,
    output logic                  o_ack,
    output rc4_pkg::key_t         o_key,
    output logic                  o_ksa_req,
    input  logic                  i_ksa_ack,
    output logic                  o_prga_req,
    input  logic                  i_prga_ack,
    output ctrl_pkg::sbox_owner_e o_owner
);
    import rc4_pkg::*;
    import ctrl_pkg::*;

    seq_state_e  state_q;
    key_t        key_q;
    logic        ksa_req_q;
    logic        prga_req_q;
    sbox_owner_e owner_q;

    assign o_ack      = (state_q == SEQ_ACK);
    assign o_key      = key_q;
    assign o_ksa_req  = ksa_req_q;
    assign o_prga_req = prga_req_q;
    assign o_owner    = owner_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= SEQ_IDLE;
            ksa_req_q  <= 1'b0;
            prga_req_q <= 1'b0;
            owner_q    <= OWN_KSA;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (i_req) begin
                        ksa_req_q <= 1'b1;
                        owner_q   <= OWN_KSA;
                        state_q   <= SEQ_SCHED;
                    end
                end
                SEQ_SCHED: begin
                    if (i_ksa_ack) begin
                        ksa_req_q <= 1'b0;
                        state_q   <= SEQ_DECRYPT;
                    end
                end
                SEQ_DECRYPT: begin
                    if (prga_req_q) begin
                        if (i_prga_ack) begin
                            prga_req_q <= 1'b0;
                            state_q    <= SEQ_ACK;
                        end
                    end else if (!i_ksa_ack && !i_prga_ack) begin
                        // memory moves over once the key schedule is idle
                        prga_req_q <= 1'b1;
                        owner_q    <= OWN_PRGA;
                    end
                end
                SEQ_ACK: begin
                    if (!i_req && !i_prga_ack) begin
                        owner_q <= OWN_KSA;
                        state_q <= SEQ_IDLE;
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == SEQ_IDLE && i_req) begin
            key_q <= i_key;
        end
    end

    assert property (@(posedge clk) disable iff (rst) $rose(o_ack) |-> $past(i_req));
    assert property (@(posedge clk) disable iff (rst)
        (i_req && $past(i_req)) |-> (i_key == $past(i_key)));

endmodule

// ==== logic/rc4_decrypt_top.sv ====
module rc4_decrypt_top #(
    parameter int  MSG_LEN = rc4_pkg::MSG_LEN_DEFAULT,
    localparam int CT_AW   = (MSG_LEN > 1) ? $clog2(MSG_LEN) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_req,
    input  rc4_pkg::key_t    i_key,
    output logic             o_ack,
    output logic [CT_AW-1:0] o_ct_addr,
    input  rc4_pkg::byte_t   i_ct_data,
    output logic             o_pt_valid,
    output logic [CT_AW-1:0] o_pt_addr,
    output rc4_pkg::byte_t   o_pt_data
);
    import rc4_pkg::*;
    import ctrl_pkg::*;

    key_t        key;
    logic        ksa_req, ksa_ack;
    logic        prga_req, prga_ack;
    sbox_owner_e owner;

    sbox_if ksa_bus ();
    sbox_if prga_bus ();
    sbox_if ram_bus ();

    rc4_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .i_req     (i_req),
        .i_key     (i_key),
        .o_ack     (o_ack),
        .o_key     (key),
        .o_ksa_req (ksa_req),
        .i_ksa_ack (ksa_ack),
        .o_prga_req(prga_req),
        .i_prga_ack(prga_ack),
        .o_owner   (owner)
    );

    key_schedule u_ksa (
        .clk  (clk),
        .rst  (rst),
        .i_req(ksa_req),
        .o_ack(ksa_ack),
        .i_key(key),
        .sbox (ksa_bus.master)
    );

    keystream_decrypt #(.MSG_LEN(MSG_LEN)) u_prga (
        .clk       (clk),
        .rst       (rst),
        .i_req     (prga_req),
        .o_ack     (prga_ack),
        .sbox      (prga_bus.master),
        .o_ct_addr (o_ct_addr),
        .i_ct_data (i_ct_data),
        .o_pt_valid(o_pt_valid),
        .o_pt_addr (o_pt_addr),
        .o_pt_data (o_pt_data)
    );

    // memory port follows the engine that owns it
    assign ram_bus.addr   = (owner == OWN_PRGA) ? prga_bus.addr  : ksa_bus.addr;
    assign ram_bus.wdata  = (owner == OWN_PRGA) ? prga_bus.wdata : ksa_bus.wdata;
    assign ram_bus.we     = (owner == OWN_PRGA) ? prga_bus.we    : ksa_bus.we;
    assign ksa_bus.rdata  = ram_bus.rdata;
    assign prga_bus.rdata = ram_bus.rdata;

    sbox_ram u_ram (
        .clk(clk),
        .mem(ram_bus.mem)
    );

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;  // half period per phase
        end
    end

endmodule

// ==== testbench/rc4_tb.sv ====
module rc4_tb;
    import rc4_pkg::*;

    localparam int MSG_LEN   = 32;
    localparam int CT_AW     = $clog2(MSG_LEN);
    localparam int NUM_VEC   = 2;
    localparam int VEC_WORDS = 1 + 2 * MSG_LEN;  // key, ciphertext, plaintext
    localparam int TIMEOUT   = 10000;

    logic             clk;
    logic             rst;
    logic             req;
    key_t             key;
    logic             ack;
    logic [CT_AW-1:0] ct_addr;
    byte_t            ct_data;
    logic             pt_valid;
    logic [CT_AW-1:0] pt_addr;
    byte_t            pt_data;

    logic [23:0] stim_mem [NUM_VEC * VEC_WORDS];
    int          cur_vec;
    int          pt_count;   // strobes seen in the current run
    string       test_name;

    tb_clock #(.PERIOD(40)) u_clk (.clk(clk));

    rc4_decrypt_top #(.MSG_LEN(MSG_LEN)) dut (
        .clk       (clk),
        .rst       (rst),
        .i_req     (req),
        .i_key     (key),
        .o_ack     (ack),
        .o_ct_addr (ct_addr),
        .i_ct_data (ct_data),
        .o_pt_valid(pt_valid),
        .o_pt_addr (pt_addr),
        .o_pt_data (pt_data)
    );

    // ========================================
    // vector access
    // ========================================

    function automatic key_t vec_key(input int v);
        return key_t'(stim_mem[v * VEC_WORDS]);
    endfunction

    function automatic byte_t vec_ct(input int v, input int k);
        return byte_t'(stim_mem[v * VEC_WORDS + 1 + k]);
    endfunction

    function automatic byte_t vec_pt(input int v, input int k);
        return byte_t'(stim_mem[v * VEC_WORDS + 1 + MSG_LEN + k]);
    endfunction

    // ========================================
    // checks
    // ========================================

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %02h, actual %02h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (ack !== level) begin
            if (cycles == TIMEOUT) begin
                abort_run($sformatf("%s: ack did not go to %0b in time", test_name, level));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            check_bit({test_name, " idle ack"}, 1'b0, ack);
            check_bit({test_name, " idle strobe"}, 1'b0, pt_valid);
        end
    endtask

    // registered read-only memory for the ciphertext
    always @(posedge clk) begin
        ct_data <= vec_ct(cur_vec, int'(ct_addr));
    end

    // plaintext monitor samples mid-cycle
    always @(negedge clk) begin
        if (!rst && pt_valid) begin
            check_bit({test_name, " strobe during ack"}, 1'b0, ack);
            check_byte({test_name, " pt addr"}, byte_t'(pt_count), byte_t'(pt_addr));
            check_byte($sformatf("%s pt data[%0d]", test_name, pt_count),
                       vec_pt(cur_vec, pt_count), pt_data);
            pt_count++;
        end
    end

    task automatic run_vector(input int v);
        int held;
        test_name = $sformatf("vec%0d", v);
        @(posedge clk);
        pt_count = 0;
        cur_vec <= v;
        key     <= vec_key(v);
        req     <= 1'b1;
        wait_ack(1'b1);
        check_byte({test_name, " strobe count"}, byte_t'(MSG_LEN), byte_t'(pt_count));
        for (held = 0; held < 4; held++) begin  // ack holds while req is up
            @(negedge clk);
            check_bit({test_name, " ack held"}, 1'b1, ack);
        end
        @(posedge clk);
        req <= 1'b0;
        wait_ack(1'b0);
    endtask

    initial begin
        rst       <= 1'b1;
        req       <= 1'b0;
        key       <= '0;
        ct_data   <= '0;
        cur_vec   <= 0;
        pt_count  = 0;
        test_name = "reset";
        $readmemh("testbench/rc4_stim.txt", stim_mem);
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        check_idle(10);
        for (int v = 0; v < NUM_VEC; v++) begin
            run_vector(v);
            check_idle(10);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== testbench/rc4_stim.txt ====
// per vector: 24-bit key, then 32 ciphertext bytes, then 32 expected plaintext bytes
// both keys are zero, so vector 1 only decodes if the sbox is rebuilt for the second run
000000
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
de 18 89 41 a3 37 5d 3a 8a 06 1e 67 57 6e 92 6d
c7 1a 7f a3 f0 cc eb 97 45 2b 4d 32 27 96 5f 9e
000000
de 19 8b 42 a7 32 5b 3d 82 0f 14 6c 5b 63 9c 62
d7 0b 6d b0 e4 d9 fd 80 5d 32 57 29 3b 8b 41 81
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f

// ==== flist.f ====
logic/rc4_pkg.sv
logic/ctrl_pkg.sv
logic/sbox_if.sv
logic/sbox_ram.sv
logic/key_schedule.sv
logic/keystream_decrypt.sv
logic/rc4_sequencer.sv
logic/rc4_decrypt_top.sv
testbench/tb_clock.sv
testbench/rc4_tb.sv

// ==== Bender.yml ====
package:
  name: rc4_decrypt

sources:
  - logic/rc4_pkg.sv
  - logic/ctrl_pkg.sv
  - logic/sbox_if.sv
  - logic/sbox_ram.sv
  - logic/key_schedule.sv
  - logic/keystream_decrypt.sv
  - logic/rc4_sequencer.sv
  - logic/rc4_decrypt_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/rc4_tb.sv
